// ==== Bender.yml ====
package:
  name: matrix_softmax

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/softmax_cmd_pkg.sv
      - source/softmax_data_pkg.sv
      - source/softmax_decode.sv
      - source/softmax_execute.sv
      - source/softmax_divider.sv
      - source/softmax_result.sv
      - source/matrix_softmax_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - testbench/matrix_softmax_assert.sv
      - testbench/tb_matrix_softmax.sv

// ==== filelist.f ====
+incdir+include
source/softmax_cmd_pkg.sv
source/softmax_data_pkg.sv
source/softmax_decode.sv
source/softmax_execute.sv
source/softmax_divider.sv
source/softmax_result.sv
source/matrix_softmax_top.sv
testbench/matrix_softmax_assert.sv
testbench/tb_matrix_softmax.sv

// ==== include/softmax_defs.svh ====
// Softmax macros: data width, fraction bits, exponent clamp, buffer depth, index width
`ifndef SOFTMAX_DEFS_SVH
`define SOFTMAX_DEFS_SVH

////////////////////
// Datapath widths
////////////////////

// Data word and divider width
`define SM_DATA_SIZE 32

// Fraction bits of each quotient
`define SM_FRAC_BITS 16

////////////////////
// Limits
////////////////////

// Largest exponent taken as is
`define SM_MAX_EXP 15

// Buffer depth, largest group
`define SM_MAX_ELEMS 64

// Width of a row or column index and of a size
`define SM_INDEX_SIZE 6

`endif

// ==== source/matrix_softmax_top.sv ====
// Matrix softmax top: decode, execute and result stages
`default_nettype none

`include "softmax_defs.svh"

module matrix_softmax_top (
  input  logic                         CLK,
  input  logic                         RST,
  input  logic                         start,
  input  softmax_cmd_pkg::sm_cmd_t     cmd,
  input  logic                         data_in_enable,
  input  logic [`SM_DATA_SIZE-1:0]     data_in,
  output logic                         accept,
  output softmax_data_pkg::sm_result_t result,
  output logic                         ready
);

  ////////////////////
  // Stage links
  ////////////////////

  // Decode to execute
  logic                        elem_valid;
  softmax_data_pkg::sm_elem_t  elem;
  // Run in progress, watched by the bound checks
  logic                        busy;

  // Execute to result
  logic                        wr_enable;
  softmax_data_pkg::sm_entry_t wr_entry;
  logic                        group_done;
  logic [`SM_DATA_SIZE-1:0]    group_sum;

  // Result back to decode
  logic                        draining;

  softmax_decode u_decode (
    .CLK            (CLK),
    .RST            (RST),
    .start          (start),
    .cmd            (cmd),
    .data_in_enable (data_in_enable),
    .data_in        (data_in),
    .draining       (draining),
    .accept         (accept),
    .elem_valid     (elem_valid),
    .elem           (elem),
    .busy           (busy)
  );

  softmax_execute u_execute (
    .CLK        (CLK),
    .RST        (RST),
    .elem_valid (elem_valid),
    .elem       (elem),
    .wr_enable  (wr_enable),
    .wr_entry   (wr_entry),
    .group_done (group_done),
    .group_sum  (group_sum)
  );

  softmax_result u_result (
    .CLK        (CLK),
    .RST        (RST),
    .wr_enable  (wr_enable),
    .wr_entry   (wr_entry),
    .group_done (group_done),
    .group_sum  (group_sum),
    .draining   (draining),
    .result     (result),
    .ready      (ready)
  );

endmodule

`default_nettype wire

// ==== source/softmax_cmd_pkg.sv ====
// Command package: opcode enum and matrix command struct
`default_nettype none

package softmax_cmd_pkg;

`include "softmax_defs.svh"

  ////////////////////
  // Opcodes
  ////////////////////

  // Group selection for the sum
  typedef enum logic {
    OP_ROW    = 1'b0, // each row normalized on its own
    OP_MATRIX = 1'b1  // one sum over the full matrix
  } sm_opcode_t;

  ////////////////////
  // Command word
  ////////////////////

  // Start a matrix of this shape
  // Sizes are counts, not last indices
  typedef struct packed {
    sm_opcode_t                 opcode;
    logic [`SM_INDEX_SIZE-1:0]  size_i;
    logic [`SM_INDEX_SIZE-1:0]  size_j;
  } sm_cmd_t;

endpackage

`default_nettype wire

// ==== source/softmax_data_pkg.sv ====
// Data package: element, buffer entry and result structs, decode and result FSM states
`default_nettype none

package softmax_data_pkg;

`include "softmax_defs.svh"

  ////////////////////
  // Datapath words
  ////////////////////

  // Input element with boundary tags from decode
  typedef struct packed {
    logic [`SM_DATA_SIZE-1:0] value;
    logic                     last_col;
    logic                     last_row;
    logic                     last_group;
  } sm_elem_t;

  // One buffer word, power of two plus its position
  typedef struct packed {
    logic [`SM_DATA_SIZE-1:0] value;
    logic                     last_col;
    logic                     last_row;
  } sm_entry_t;

  // Output quotient and its strobes
  typedef struct packed {
    logic [`SM_DATA_SIZE-1:0] value;
    logic                     scalar_enable;
    logic                     vector_enable;
    logic                     matrix_enable;
  } sm_result_t;

  ////////////////////
  // FSM states
  ////////////////////

  typedef enum logic {
    IDLE,
    STREAM
  } sm_decode_state_t;

  typedef enum logic [1:0] {
    WAIT,
    LOAD,
    DIVIDE,
    EMIT
  } sm_result_state_t;

endpackage

`default_nettype wire

// ==== source/softmax_decode.sv ====
// Softmax decode: command capture, row and column counters, element boundary tagging
`default_nettype none

`include "softmax_defs.svh"

module softmax_decode (
  input  logic                          CLK,
  input  logic                          RST,
  input  logic                          start,
  input  softmax_cmd_pkg::sm_cmd_t      cmd,
  input  logic                          data_in_enable,
  input  logic [`SM_DATA_SIZE-1:0]      data_in,
  input  logic                          draining,
  output logic                          accept,
  output logic                          elem_valid,
  output softmax_data_pkg::sm_elem_t    elem,
  output logic                          busy
);

  localparam logic [`SM_INDEX_SIZE-1:0] IDX_ONE = 1;

  softmax_data_pkg::sm_decode_state_t state;

  // Shape of the running matrix
  softmax_cmd_pkg::sm_opcode_t  opcode_q;
  logic [`SM_INDEX_SIZE-1:0]    size_i_q;
  logic [`SM_INDEX_SIZE-1:0]    size_j_q;

  // Index loops
  logic [`SM_INDEX_SIZE-1:0]    col;
  logic [`SM_INDEX_SIZE-1:0]    row;

  logic hold;     // group closed, waiting for drain
  logic final_q;  // last matrix element taken
  logic take;
  logic last_col;
  logic last_row;
  logic last_group;

  ////////////////////
  // Tags
  ////////////////////

  assign last_col = (col == size_j_q - IDX_ONE);
  assign last_row = (row == size_i_q - IDX_ONE);
  // Row mode closes a group at each row end
  assign last_group = last_col && (last_row || (opcode_q == softmax_cmd_pkg::OP_ROW));

  assign accept = (state == softmax_data_pkg::STREAM) && !hold && !draining && !final_q;
  assign take   = data_in_enable && accept;
  assign busy   = (state == softmax_data_pkg::STREAM);

  ////////////////////
  // Control FSM
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state      <= softmax_data_pkg::IDLE;
      col        <= '0;
      row        <= '0;
      hold       <= 1'b0;
      final_q    <= 1'b0;
      elem_valid <= 1'b0;
    end else begin
      elem_valid <= take;
      case (state)
        softmax_data_pkg::IDLE: begin
          if (start) begin
            col     <= '0;
            row     <= '0;
            hold    <= 1'b0;
            final_q <= 1'b0;
            state   <= softmax_data_pkg::STREAM;
          end
        end
        default: begin
          if (take) begin
            // Column loop wraps into the row loop
            if (last_col) begin
              col <= '0;
              row <= row + IDX_ONE;
            end else begin
              col <= col + IDX_ONE;
            end
            hold    <= last_group;
            final_q <= last_col && last_row;
          end
          // Drain has started, let it finish
          if (hold && draining) begin
            hold <= 1'b0;
          end
          if (final_q && !hold && !draining) begin
            state <= softmax_data_pkg::IDLE;
          end
        end
      endcase
    end
  end

  // Command and element payload
  always_ff @(posedge CLK) begin
    if (start && (state == softmax_data_pkg::IDLE)) begin
      opcode_q <= cmd.opcode;
      size_i_q <= cmd.size_i;
      size_j_q <= cmd.size_j;
    end
    if (take) begin
      elem <= '{value: data_in, last_col: last_col, last_row: last_row,
                last_group: last_group};
    end
  end

endmodule

`default_nettype wire

// ==== source/softmax_divider.sv ====
// Serial restoring divider, one quotient bit per cycle
`default_nettype none

`include "softmax_defs.svh"

module softmax_divider (
  input  logic                     CLK,
  input  logic                     RST,
  input  logic                     load,
  input  logic [`SM_DATA_SIZE-1:0] dividend,
  input  logic [`SM_DATA_SIZE-1:0] divisor,
  output logic                     done,
  output logic [`SM_DATA_SIZE-1:0] quotient
);

  localparam int CNT_W = $clog2(`SM_DATA_SIZE + 1);

  logic                     active;
  logic [CNT_W-1:0]         count;
  logic [`SM_DATA_SIZE-1:0] rem;
  logic [`SM_DATA_SIZE-1:0] div_q;
  logic [`SM_DATA_SIZE:0]   trial;
  logic [`SM_DATA_SIZE:0]   diff;
  logic                     q_bit;

  // Shift in next dividend bit, try subtract
  assign trial = {rem, quotient[`SM_DATA_SIZE-1]};
  assign diff  = trial - {1'b0, div_q};
  // Sign clear means the subtract fits
  assign q_bit = !diff[`SM_DATA_SIZE];

  ////////////////////
  // Step counter
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      active <= 1'b0;
      count  <= '0;
      done   <= 1'b0;
    end else begin
      done <= 1'b0;
      if (load) begin
        active <= 1'b1;
        count  <= CNT_W'(`SM_DATA_SIZE);
      end else if (active) begin
        count <= count - 1'b1;
        if (count == CNT_W'(1)) begin
          active <= 1'b0;
          done   <= 1'b1;
        end
      end
    end
  end

  // Quotient shifts in from the right as dividend bits leave
  always_ff @(posedge CLK) begin
    if (load) begin
      rem      <= '0;
      quotient <= dividend;
      div_q    <= divisor;
    end else if (active) begin
      rem      <= q_bit ? diff[`SM_DATA_SIZE-1:0] : trial[`SM_DATA_SIZE-1:0];
      quotient <= {quotient[`SM_DATA_SIZE-2:0], q_bit};
    end
  end

endmodule

`default_nettype wire

// ==== source/softmax_execute.sv ====
// Softmax execute: exponent clamp, power of two, group sum accumulation, buffer write
`default_nettype none

`include "softmax_defs.svh"

module softmax_execute (
  input  logic                        CLK,
  input  logic                        RST,
  input  logic                        elem_valid,
  input  softmax_data_pkg::sm_elem_t  elem,
  output logic                        wr_enable,
  output softmax_data_pkg::sm_entry_t wr_entry,
  output logic                        group_done,
  output logic [`SM_DATA_SIZE-1:0]    group_sum
);

  // Enough bits for the clamped exponent
  localparam int EXP_W = $clog2(`SM_MAX_EXP + 1);

  localparam logic [`SM_DATA_SIZE-1:0] ONE_WORD = 1;

  logic [EXP_W-1:0]         exp_clamped;
  logic [`SM_DATA_SIZE-1:0] pow_value;
  logic [`SM_DATA_SIZE-1:0] sum_acc;
  logic [`SM_DATA_SIZE-1:0] sum_next;

  ////////////////////
  // Exponent
  ////////////////////

  // Saturate large exponents
  always_comb begin
    if (elem.value > `SM_MAX_EXP) begin
      exp_clamped = EXP_W'(`SM_MAX_EXP);
    end else begin
      exp_clamped = elem.value[EXP_W-1:0];
    end
  end

  // Base two exponential
  assign pow_value = ONE_WORD << exp_clamped;

  // Sum including this element
  assign sum_next = sum_acc + pow_value;

  ////////////////////
  // Accumulator
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      sum_acc    <= '0;
      wr_enable  <= 1'b0;
      group_done <= 1'b0;
    end else begin
      wr_enable  <= elem_valid;
      group_done <= elem_valid && elem.last_group;
      if (elem_valid) begin
        // Group end restarts the sum
        if (elem.last_group) begin
          sum_acc <= '0;
        end else begin
          sum_acc <= sum_next;
        end
      end
    end
  end

  ////////////////////
  // Buffer word
  ////////////////////

  // Entry and final sum, qualified by the strobes above
  always_ff @(posedge CLK) begin
    if (elem_valid) begin
      wr_entry.value    <= pow_value;
      wr_entry.last_col <= elem.last_col;
      wr_entry.last_row <= elem.last_row;
      group_sum         <= sum_next;
    end
  end

endmodule

`default_nettype wire

// ==== source/softmax_result.sv ====
// Softmax result: exponent buffer, drain FSM, divider, output strobes
`default_nettype none

`include "softmax_defs.svh"

module softmax_result (
  input  logic                         CLK,
  input  logic                         RST,
  input  logic                         wr_enable,
  input  softmax_data_pkg::sm_entry_t  wr_entry,
  input  logic                         group_done,
  input  logic [`SM_DATA_SIZE-1:0]     group_sum,
  output logic                         draining,
  output softmax_data_pkg::sm_result_t result,
  output logic                         ready
);

  localparam logic [`SM_INDEX_SIZE-1:0] IDX_ONE = 1;

  softmax_data_pkg::sm_result_state_t state;
  softmax_data_pkg::sm_entry_t        buffer [`SM_MAX_ELEMS];
  softmax_data_pkg::sm_entry_t        rd_entry;

  logic [`SM_INDEX_SIZE-1:0] wr_ptr;
  logic [`SM_INDEX_SIZE-1:0] rd_ptr;
  logic [`SM_INDEX_SIZE-1:0] rd_next;
  logic                      last_entry;
  logic [`SM_DATA_SIZE-1:0]  sum_q;
  logic [`SM_DATA_SIZE-1:0]  quotient;
  logic [`SM_DATA_SIZE-1:0]  value_q;
  logic                      div_done;
  logic                      scalar_q;
  logic                      vector_q;
  logic                      matrix_q;

  assign rd_entry   = buffer[rd_ptr];
  assign rd_next    = rd_ptr + IDX_ONE;
  // Wraps to zero on a full buffer
  assign last_entry = (rd_next == wr_ptr);

  always_ff @(posedge CLK) begin
    if (wr_enable) begin
      buffer[wr_ptr] <= wr_entry;
    end
    if (group_done) begin
      sum_q <= group_sum;
    end
    if (div_done) begin
      value_q <= quotient;
    end
  end

  ////////////////////
  // Drain FSM
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= softmax_data_pkg::WAIT;
      wr_ptr <= '0;
      rd_ptr <= '0;
      draining <= 1'b0;
      scalar_q <= 1'b0;
      vector_q <= 1'b0;
      matrix_q <= 1'b0;
    end else begin
      scalar_q <= 1'b0;
      vector_q <= 1'b0;
      matrix_q <= 1'b0;
      if (wr_enable) wr_ptr <= wr_ptr + IDX_ONE;
      case (state)
        softmax_data_pkg::WAIT: if (group_done) begin
          rd_ptr <= '0;
          draining <= 1'b1;
          state <= softmax_data_pkg::LOAD;
        end
        softmax_data_pkg::LOAD: state <= softmax_data_pkg::DIVIDE;
        softmax_data_pkg::DIVIDE: if (div_done) begin
          // Strobes follow the entry position
          scalar_q <= 1'b1;
          vector_q <= rd_entry.last_col;
          matrix_q <= rd_entry.last_col && rd_entry.last_row;
          state <= softmax_data_pkg::EMIT;
        end
        default: if (last_entry) begin
          wr_ptr <= '0;
          rd_ptr <= '0;
          draining <= 1'b0;
          state <= softmax_data_pkg::WAIT;
        end else begin
          rd_ptr <= rd_next;
          state <= softmax_data_pkg::LOAD;
        end
      endcase
    end
  end

  // Scaled power over the group sum
  softmax_divider u_divider (
    .CLK      (CLK),
    .RST      (RST),
    .load     (state == softmax_data_pkg::LOAD),
    .dividend (rd_entry.value << `SM_FRAC_BITS),
    .divisor  (sum_q),
    .done     (div_done),
    .quotient (quotient)
  );

  assign result = '{value: value_q, scalar_enable: scalar_q, vector_enable: vector_q,
                    matrix_enable: matrix_q};
  assign ready  = matrix_q;

endmodule

`default_nettype wire

// ==== testbench/matrix_softmax_assert.sv ====
// Concurrent checks on matrix softmax top-level strobes, bound to the top level
`default_nettype none

module matrix_softmax_assert (
  input logic                         CLK,
  input logic                         RST,
  input logic                         accept,
  input logic                         busy,
  input softmax_data_pkg::sm_result_t result,
  input logic                         ready
);

  ////////////////////
  // Strobe relations
  ////////////////////

  // Final quotient carries every strobe
  ready_has_strobes: assert property (@(posedge CLK) disable iff (RST)
    ready |-> (result.matrix_enable && result.scalar_enable))
    else $error("ready without matrix and scalar strobes");

  // Row end only on a real quotient
  vector_has_scalar: assert property (@(posedge CLK) disable iff (RST)
    result.vector_enable |-> result.scalar_enable)
    else $error("vector strobe without scalar strobe");

  // No input while a group drains
  no_accept_on_result: assert property (@(posedge CLK) disable iff (RST)
    result.scalar_enable |-> !accept)
    else $error("accept high during a result strobe");

  // Quotients only while decode holds a run
  result_in_run: assert property (@(posedge CLK) disable iff (RST)
    result.scalar_enable |-> busy)
    else $error("result strobe while decode is idle");

  ////////////////////
  // Known values
  ////////////////////

  strobes_known: assert property (@(posedge CLK) disable iff (RST)
    !$isunknown({accept, ready, result.scalar_enable, result.vector_enable,
                 result.matrix_enable}))
    else $error("unknown value on a strobe");

endmodule

bind matrix_softmax_top matrix_softmax_assert u_assert (
  .CLK    (CLK),
  .RST    (RST),
  .accept (accept),
  .busy   (busy),
  .result (result),
  .ready  (ready)
);

`default_nettype wire

// ==== testbench/tb_matrix_softmax.sv ====
// Matrix softmax testbench: clock, reset, watchdog, reference model, directed test tasks
`default_nettype none

`include "softmax_defs.svh"

module tb_matrix_softmax;

  localparam int DRIVE_DELAY  = 2;
  localparam int RESET_CYCLES = 16;
  // Row, matrix, clamp, noisy, then two random runs
  localparam int TOTAL_ELEMS  = 8 + 9 + 8 + 8 + 32 + 32;
  localparam int NUM_RUNS     = 6;
  // Quiet window after each run
  localparam int QUIET_CYCLES = `SM_DATA_SIZE + 8;
  localparam int WATCHDOG_CYCLES = TOTAL_ELEMS * (`SM_DATA_SIZE + 8) + NUM_RUNS * QUIET_CYCLES
                                   + RESET_CYCLES + 200;
  localparam logic [`SM_INDEX_SIZE-1:0] IDX_ONE = 1;

  logic                         CLK;
  logic                         RST;
  logic                         start;
  softmax_cmd_pkg::sm_cmd_t     cmd;
  logic                         data_in_enable;
  logic [`SM_DATA_SIZE-1:0]     data_in;
  logic                         accept;
  softmax_data_pkg::sm_result_t result;
  logic                         ready;

  integer seed = 32'h1ededb8d;
  int     error_count = 0;

  // One matrix of stimulus, its model and what came back
  logic [`SM_DATA_SIZE-1:0] elems[$];
  logic [`SM_DATA_SIZE-1:0] exp_value[$];
  logic                     exp_vec[$];
  logic                     exp_mat[$];
  logic [`SM_DATA_SIZE-1:0] got_value[$];
  int                       scalar_cnt;
  int                       vector_cnt;
  int                       matrix_cnt;

  matrix_softmax_top dut (
    .CLK            (CLK),
    .RST            (RST),
    .start          (start),
    .cmd            (cmd),
    .data_in_enable (data_in_enable),
    .data_in        (data_in),
    .accept         (accept),
    .result         (result),
    .ready          (ready)
  );

  always #10 CLK = ~CLK;

  task automatic check_value(input logic [`SM_DATA_SIZE-1:0] actual,
                             input logic [`SM_DATA_SIZE-1:0] expected, input string what);
    if (actual !== expected) begin
      error_count++;
      $display("ERR %0t: %s, got %0h expected %0h", $time, what, actual, expected);
      $display("Test FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  ////////////////////
  // Reference model
  ////////////////////

  // Base two with the exponent clamp
  function automatic longint unsigned pow2_clamped(input logic [`SM_DATA_SIZE-1:0] x);
    if (x > `SM_MAX_EXP) begin
      return 64'd1 << `SM_MAX_EXP;
    end
    return 64'd1 << x;
  endfunction

  // Quotients per group, a group being one row or all rows
  task automatic build_expected(input softmax_cmd_pkg::sm_opcode_t op, input int si,
                                input int sj);
    int                first_row;
    int                end_row;
    int                r;
    int                c;
    longint unsigned   sum;
    exp_value.delete();
    exp_vec.delete();
    exp_mat.delete();
    first_row = 0;
    while (first_row < si) begin
      end_row = (op == softmax_cmd_pkg::OP_ROW) ? first_row : si - 1;
      sum = 0;
      for (r = first_row; r <= end_row; r++) begin
        for (c = 0; c < sj; c++) begin
          sum += pow2_clamped(elems[r * sj + c]);
        end
      end
      for (r = first_row; r <= end_row; r++) begin
        for (c = 0; c < sj; c++) begin
          exp_value.push_back((pow2_clamped(elems[r * sj + c]) << `SM_FRAC_BITS) / sum);
          exp_vec.push_back(c == sj - 1);
          exp_mat.push_back((r == si - 1) && (c == sj - 1));
        end
      end
      first_row = end_row + 1;
    end
  endtask

  ////////////////////
  // Drivers and monitor
  ////////////////////

  task automatic send_start(input softmax_cmd_pkg::sm_opcode_t op, input int si, input int sj,
                            input bit noisy);
    @(posedge CLK);
    #DRIVE_DELAY;
    start          = 1'b1;
    cmd.opcode     = op;
    cmd.size_i     = si[`SM_INDEX_SIZE-1:0];
    cmd.size_j     = sj[`SM_INDEX_SIZE-1:0];
    // Strobe while idle gets dropped
    data_in_enable = noisy;
    data_in        = $random(seed);
    @(posedge CLK);
    #DRIVE_DELAY;
    start          = 1'b0;
    data_in_enable = 1'b0;
    check_value(accept, 1, "accept one cycle after start");
  endtask

  // Offer the next element whenever accept is high
  task automatic feed_elements(input bit noisy, input softmax_cmd_pkg::sm_opcode_t other_op);
    int idx;
    bit start_sent;
    idx = 0;
    start_sent = 1'b0;
    while (idx < elems.size()) begin
      if (accept) begin
        data_in_enable = 1'b1;
        data_in        = elems[idx];
        idx++;
      end else begin
        data_in_enable = noisy;
        data_in        = $random(seed);
        // One stray command in mid run
        if (noisy && !start_sent) begin
          start      = 1'b1;
          cmd.opcode = other_op;
          cmd.size_i = IDX_ONE;
          cmd.size_j = IDX_ONE;
          start_sent = 1'b1;
        end
      end
      @(posedge CLK);
      #DRIVE_DELAY;
      start = 1'b0;
    end
    data_in_enable = 1'b0;
  endtask

  task automatic collect_results();
    int count;
    count = 0;
    scalar_cnt = 0;
    vector_cnt = 0;
    matrix_cnt = 0;
    got_value.delete();
    while (count < exp_value.size()) begin
      @(negedge CLK);
      scalar_cnt += result.scalar_enable;
      vector_cnt += result.vector_enable;
      matrix_cnt += result.matrix_enable;
      if (result.scalar_enable) begin
        check_value(result.value, exp_value[count], $sformatf("quotient %0d", count));
        check_value(result.vector_enable, exp_vec[count], $sformatf("row end %0d", count));
        check_value(result.matrix_enable, exp_mat[count], $sformatf("matrix end %0d", count));
        check_value(ready, exp_mat[count], $sformatf("ready at %0d", count));
        got_value.push_back(result.value);
        count++;
      end
    end
  endtask

  task automatic run_matrix(input softmax_cmd_pkg::sm_opcode_t op, input int si, input int sj,
                            input bit noisy);
    softmax_cmd_pkg::sm_opcode_t other_op;
    other_op = (op == softmax_cmd_pkg::OP_ROW) ? softmax_cmd_pkg::OP_MATRIX
                                               : softmax_cmd_pkg::OP_ROW;
    build_expected(op, si, sj);
    send_start(op, si, sj, noisy);
    fork
      feed_elements(noisy, other_op);
      collect_results();
    join
    // Keep counting long enough for one more quotient to show up
    repeat (QUIET_CYCLES) begin
      @(negedge CLK);
      scalar_cnt += result.scalar_enable;
      vector_cnt += result.vector_enable;
      matrix_cnt += result.matrix_enable;
    end
    check_value(scalar_cnt, si * sj, "scalar strobe count");
    check_value(vector_cnt, si, "vector strobe count");
    check_value(matrix_cnt, 1, "matrix strobe count");
  endtask

  ////////////////////
  // Directed tests
  ////////////////////

  task automatic test_row_mode();
    elems = '{0, 1, 2, 3, 5, 4, 4, 1};
    run_matrix(softmax_cmd_pkg::OP_ROW, 2, 4, 1'b0);
  endtask

  task automatic test_matrix_mode();
    elems = '{2, 0, 7, 1, 1, 3, 9, 4, 0};
    run_matrix(softmax_cmd_pkg::OP_MATRIX, 3, 3, 1'b0);
  endtask

  // Large exponents must match exponent 15 exactly
  task automatic test_saturation();
    elems = '{15, 16, 1000, 32'hffff_ffff, 3, 15, 31, 7};
    run_matrix(softmax_cmd_pkg::OP_ROW, 2, 4, 1'b0);
    // Row 0 saturates fully, four equal terms share the sum
    for (int k = 0; k < 4; k++) begin
      check_value(got_value[k], (32'd1 << `SM_FRAC_BITS) / 4,
                  $sformatf("saturated quotient %0d", k));
    end
  endtask

  task automatic test_ignored_strobes();
    elems = '{4, 1, 0, 2, 6, 6, 3, 0};
    run_matrix(softmax_cmd_pkg::OP_ROW, 2, 4, 1'b1);
  endtask

  task automatic fill_random(input int count);
    elems.delete();
    repeat (count) begin
      elems.push_back($unsigned($random(seed)) % 20);
    end
  endtask

  task automatic test_random();
    fill_random(32);
    run_matrix(softmax_cmd_pkg::OP_ROW, 4, 8, 1'b0);
    fill_random(32);
    run_matrix(softmax_cmd_pkg::OP_MATRIX, 4, 8, 1'b0);
  endtask

  initial begin
    CLK            = 1'b0;
    RST            = 1'b1;
    start          = 1'b0;
    cmd            = '0;
    data_in_enable = 1'b0;
    data_in        = '0;
    repeat (RESET_CYCLES) @(posedge CLK);
    #DRIVE_DELAY;
    RST = 1'b0;
    check_value(accept, 0, "accept after reset");
    check_value(ready, 0, "ready after reset");
    check_value(result.scalar_enable, 0, "scalar strobe after reset");
    test_row_mode();
    test_matrix_mode();
    test_saturation();
    test_ignored_strobes();
    test_random();
    if (error_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // Watchdog sized from the element count
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Test FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire
